// ==== rtl/uncorePkg.sv ====
package uncorePkg;

  ////////////////////////////////////////////////////
  // bus widths and transfer encodings
  ////////////////////////////////////////////////////

  localparam int XLen = 32;

  // only nonsequential single transfers are served
  localparam logic [1:0] TransNonSeq = 2'b10;

  // hSize encodings up to the bus width
  localparam logic [2:0] SizeByte = 3'd0;
  localparam logic [2:0] SizeHalf = 3'd1;
  localparam logic [2:0] SizeWord = 3'd2;

  // address phase as seen by decoder and slaves
  typedef struct packed {
    logic [31:0] addr;
    logic        write;
    logic [2:0]  size;
    logic [1:0]  trans;
    // bus hReady, fed back from the response mux
    logic        ready;
  } ahbAdrT;

  // per-slave data-phase response
  typedef struct packed {
    logic [XLen-1:0] rData;
    logic            ready;
    logic            resp;
  } ahbRspT;

  // one bit per region, none catches unmapped or illegal accesses
  typedef struct packed {
    logic none;
    logic ext;
    logic ram;
    logic clint;
    logic gpio;
  } selVecT;

  // select value for an idle or reset data phase
  localparam selVecT SelNone = '{none: 1'b1, ext: 1'b0, ram: 1'b0, clint: 1'b0, gpio: 1'b0};

  ////////////////////////////////////////////////////
  // memory map
  ////////////////////////////////////////////////////

  localparam logic [31:0] RamBase   = 32'h8000_0000;
  localparam logic [31:0] RamRange  = 32'h0000_0FFF;
  localparam logic [31:0] ClintBase = 32'h0200_0000;
  localparam logic [31:0] ClintRange = 32'h0000_FFFF;
  localparam logic [31:0] GpioBase  = 32'h1006_0000;
  localparam logic [31:0] GpioRange = 32'h0000_00FF;
  localparam logic [31:0] ExtBase   = 32'h9000_0000;
  localparam logic [31:0] ExtRange  = 32'h0FFF_FFFF;

  localparam int RamWords = 1024;

  // clint register offsets
  localparam logic [15:0] MsipOff       = 16'h0000;
  localparam logic [15:0] MTimeCmpOff   = 16'h4000;
  localparam logic [15:0] MTimeCmpHiOff = 16'h4004;
  localparam logic [15:0] MTimeOff      = 16'hBFF8;
  localparam logic [15:0] MTimeHiOff    = 16'hBFFC;

  // gpio register offsets
  localparam logic [7:0] InputValOff  = 8'h00;
  localparam logic [7:0] InputEnOff   = 8'h04;
  localparam logic [7:0] OutputEnOff  = 8'h08;
  localparam logic [7:0] OutputValOff = 8'h0C;
  localparam logic [7:0] RiseIeOff    = 8'h18;
  localparam logic [7:0] RiseIpOff    = 8'h1C;

endpackage

// ==== rtl/adrDecode.sv ====
`timescale 1ns/1ns

module adrDecode import uncorePkg::*; (
  input  ahbAdrT adr,
  output selVecT sel
);

  logic active;
  logic aligned;
  logic wordAcc;
  logic hitRam, hitClint, hitGpio, hitExt;

  // idle and sequential transfers select nothing
  assign active = (adr.trans == TransNonSeq);

  // region hits, every base is aligned to its range
  assign hitRam   = (adr.addr & ~RamRange) == RamBase;
  assign hitClint = (adr.addr & ~ClintRange) == ClintBase;
  assign hitGpio  = (adr.addr & ~GpioRange) == GpioBase;
  assign hitExt   = (adr.addr & ~ExtRange) == ExtBase;

  // natural alignment, nothing wider than the bus
  always_comb begin
    case (adr.size)
      SizeByte: aligned = 1'b1;
      SizeHalf: aligned = ~adr.addr[0];
      SizeWord: aligned = (adr.addr[1:0] == 2'b00);
      default:  aligned = 1'b0;
    endcase
  end

  // clint and gpio registers take full words only
  assign wordAcc = (adr.size == SizeWord);

  always_comb begin
    sel.ram   = active & hitRam & aligned;
    sel.ext   = active & hitExt & aligned;
    sel.clint = active & hitClint & aligned & wordAcc;
    sel.gpio  = active & hitGpio & aligned & wordAcc;
    // anything active that fell through lands on none
    sel.none  = active & ~(sel.ram | sel.ext | sel.clint | sel.gpio);
  end

endmodule

// ==== rtl/ahbRespMux.sv ====
`timescale 1ns/1ns

module ahbRespMux import uncorePkg::*; (
  input  logic   HCLK,
  input  logic   arstN,
  input  selVecT sel,
  input  ahbRspT rspRam,
  input  ahbRspT rspClint,
  input  ahbRspT rspGpio,
  input  ahbRspT rspExt,
  output ahbRspT rsp
);

  selVecT dSel;

  ////////////////////////////////////////////////////
  // data-phase select
  ////////////////////////////////////////////////////

  // loaded on every accepted address phase
  // an idle slot maps to none so the next data phase completes at once
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      dSel <= SelNone;
    end else if (rsp.ready) begin
      dSel <= (sel == '0) ? SelNone : sel;
    end
  end

  ////////////////////////////////////////////////////
  // and-or response mux
  ////////////////////////////////////////////////////

  always_comb begin
    // none returns zero data, so it adds no term here
    rsp.rData = ({XLen{dSel.ram}}   & rspRam.rData)   |
                ({XLen{dSel.clint}} & rspClint.rData) |
                ({XLen{dSel.gpio}}  & rspGpio.rData)  |
                ({XLen{dSel.ext}}   & rspExt.rData);
    // none is always ready, keeps the bus from hanging
    rsp.ready = dSel.none |
                (dSel.ram & rspRam.ready) |
                (dSel.clint & rspClint.ready) |
                (dSel.gpio & rspGpio.ready) |
                (dSel.ext & rspExt.ready);
    rsp.resp  = (dSel.ram & rspRam.resp) |
                (dSel.clint & rspClint.resp) |
                (dSel.gpio & rspGpio.resp) |
                (dSel.ext & rspExt.resp);
  end

  // decoder and idle mapping together must leave exactly one owner
  assert property (@(posedge HCLK) disable iff (!arstN) $onehot(dSel));

endmodule

// ==== rtl/ahbRam.sv ====
`timescale 1ns/1ns

module ahbRam import uncorePkg::*; (
  input  logic            HCLK,
  input  logic            arstN,
  input  logic            sel,
  input  ahbAdrT          adr,
  input  logic [XLen-1:0] wData,
  output ahbRspT          rsp
);

  localparam int IdxW = $clog2(RamWords);

  logic [XLen-1:0] mem [RamWords];

  logic              dWrite;
  logic [31:0]       dAddr;
  logic [2:0]        dSize;
  logic [IdxW-1:0]   dIdx;
  logic [XLen/8-1:0] byteEn;

  ////////////////////////////////////////////////////
  // address phase capture
  ////////////////////////////////////////////////////

  // pending write flag
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      dWrite <= 1'b0;
    end else if (adr.ready) begin
      dWrite <= sel & adr.write;
    end
  end

  // address and size of the accepted access
  always_ff @(posedge HCLK) begin
    if (adr.ready && sel) begin
      dAddr <= adr.addr;
      dSize <= adr.size;
    end
  end

  assign dIdx = dAddr[IdxW+1:2];

  ////////////////////////////////////////////////////
  // data phase
  ////////////////////////////////////////////////////

  // lanes picked by size and the low address bits
  always_comb begin
    case (dSize)
      SizeByte: byteEn = 4'b0001 << dAddr[1:0];
      SizeHalf: byteEn = dAddr[1] ? 4'b1100 : 4'b0011;
      default:  byteEn = 4'b1111;
    endcase
  end

  // commit on the edge that closes the data phase
  always_ff @(posedge HCLK) begin
    if (dWrite && adr.ready) begin
      for (int i = 0; i < XLen/8; i++) begin
        if (byteEn[i]) begin
          mem[dIdx][8*i +: 8] <= wData[8*i +: 8];
        end
      end
    end
  end

  // asynchronous read, a read right after a write sees the new word
  // master picks its own lanes out of the full word
  assign rsp.rData = mem[dIdx];
  // zero wait states, never an error
  assign rsp.ready = 1'b1;
  assign rsp.resp  = 1'b0;

  // decoder must never hand the ram a write beyond its last word
  assert property (@(posedge HCLK) disable iff (!arstN)
    dWrite |-> (((dAddr - RamBase) >> 2) < RamWords));

endmodule

// ==== rtl/clint.sv ====
`timescale 1ns/1ns

module clint import uncorePkg::*; (
  input  logic            HCLK,
  input  logic            arstN,
  input  logic            sel,
  input  ahbAdrT          adr,
  input  logic [XLen-1:0] wData,
  output ahbRspT          rsp,
  output logic            mTimerInt,
  output logic            mSwInt,
  output logic [63:0]     mTime
);

  logic        dWrite;
  logic [15:0] dOff;
  logic        wr;
  logic [63:0] mTimeCmp;
  logic        msip;

  ////////////////////////////////////////////////////
  // bus side
  ////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      dWrite <= 1'b0;
    end else if (adr.ready) begin
      dWrite <= sel & adr.write;
    end
  end

  // register offset inside the 64 KiB window
  always_ff @(posedge HCLK) begin
    if (adr.ready && sel) begin
      dOff <= adr.addr[15:0];
    end
  end

  // write strobe at the end of the data phase
  assign wr = dWrite & adr.ready;

  ////////////////////////////////////////////////////
  // timer and software interrupt state
  ////////////////////////////////////////////////////

  // counts HCLK, a half write replaces that half for one cycle
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      mTime <= '0;
    end else if (wr && dOff == MTimeOff) begin
      mTime <= {mTime[63:32], wData};
    end else if (wr && dOff == MTimeHiOff) begin
      mTime <= {wData, mTime[31:0]};
    end else begin
      mTime <= mTime + 64'd1;
    end
  end

  // compare starts at all ones so no timer interrupt out of reset
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      mTimeCmp <= '1;
      msip     <= 1'b0;
    end else if (wr) begin
      case (dOff)
        MTimeCmpOff:   mTimeCmp[31:0]  <= wData;
        MTimeCmpHiOff: mTimeCmp[63:32] <= wData;
        MsipOff:       msip            <= wData[0];
        default:       ;
      endcase
    end
  end

  assign mTimerInt = (mTime >= mTimeCmp);
  assign mSwInt    = msip;

  // read mux, holes read as zero
  always_comb begin
    case (dOff)
      MsipOff:       rsp.rData = {{(XLen-1){1'b0}}, msip};
      MTimeCmpOff:   rsp.rData = mTimeCmp[31:0];
      MTimeCmpHiOff: rsp.rData = mTimeCmp[63:32];
      MTimeOff:      rsp.rData = mTime[31:0];
      MTimeHiOff:    rsp.rData = mTime[63:32];
      default:       rsp.rData = '0;
    endcase
  end

  assign rsp.ready = 1'b1;
  assign rsp.resp  = 1'b0;

endmodule

// ==== rtl/gpio.sv ====
`timescale 1ns/1ns

module gpio import uncorePkg::*; (
  input  logic            HCLK,
  input  logic            arstN,
  input  logic            sel,
  input  ahbAdrT          adr,
  input  logic [XLen-1:0] wData,
  output ahbRspT          rsp,
  input  logic [XLen-1:0] gpioPinsIn,
  output logic [XLen-1:0] gpioPinsOut,
  output logic [XLen-1:0] gpioPinsEn,
  output logic            gpioIntr
);

  logic            dWrite;
  logic [7:0]      dOff;
  logic            wr;
  logic [XLen-1:0] syncIn, inputVal, prevVal, rise;
  logic [XLen-1:0] inputEn, outputEn, outputVal, riseIe, riseIp;

  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      dWrite <= 1'b0;
    end else if (adr.ready) begin
      dWrite <= sel & adr.write;
    end
  end

  always_ff @(posedge HCLK) begin
    if (adr.ready && sel) begin
      dOff <= adr.addr[7:0];
    end
  end

  assign wr = dWrite & adr.ready;

  ////////////////////////////////////////////////////
  // input path and edge detect
  ////////////////////////////////////////////////////

  // two flops from pin to inputVal, second stage masked by inputEn
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      syncIn   <= '0;
      inputVal <= '0;
      prevVal  <= '0;
    end else begin
      syncIn   <= gpioPinsIn;
      inputVal <= syncIn & inputEn;
      prevVal  <= inputVal;
    end
  end

  assign rise = inputVal & ~prevVal;

  ////////////////////////////////////////////////////
  // control registers
  ////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      inputEn   <= '0;
      outputEn  <= '0;
      outputVal <= '0;
      riseIe    <= '0;
      riseIp    <= '0;
    end else begin
      if (wr && dOff == InputEnOff) inputEn <= wData;
      if (wr && dOff == OutputEnOff) outputEn <= wData;
      if (wr && dOff == OutputValOff) outputVal <= wData;
      if (wr && dOff == RiseIeOff) riseIe <= wData;
      // write one to clear, a new edge in the same cycle wins
      riseIp <= (riseIp & ~((wr && dOff == RiseIpOff) ? wData : '0)) | rise;
    end
  end

  assign gpioPinsOut = outputVal;
  assign gpioPinsEn  = outputEn;
  assign gpioIntr    = |(riseIe & riseIp);

  always_comb begin
    case (dOff)
      InputValOff:  rsp.rData = inputVal;
      InputEnOff:   rsp.rData = inputEn;
      OutputEnOff:  rsp.rData = outputEn;
      OutputValOff: rsp.rData = outputVal;
      RiseIeOff:    rsp.rData = riseIe;
      RiseIpOff:    rsp.rData = riseIp;
      default:      rsp.rData = '0;
    endcase
  end

  assign rsp.ready = 1'b1;
  assign rsp.resp  = 1'b0;

  // new pending bits trace back through the sync stage to an enabled input
  assert property (@(posedge HCLK) disable iff (!arstN)
    (riseIp & ~$past(riseIp) & ~$past(inputEn, 2)) == '0);

endmodule

// ==== rtl/uncore.sv ====
`timescale 1ns/1ns

module uncore import uncorePkg::*; (
  input  logic            HCLK,
  input  logic            arstN,
  // ahb-lite slave side
  input  logic [31:0]     hAddr,
  input  logic [XLen-1:0] hWData,
  input  logic            hWrite,
  input  logic [2:0]      hSize,
  input  logic [1:0]      hTrans,
  // external slave response
  input  logic [XLen-1:0] hRDataExt,
  input  logic            hReadyExt,
  input  logic            hRespExt,
  output logic [XLen-1:0] hRData,
  output logic            hReady,
  output logic            hResp,
  output logic            hSelExt,
  // interrupts and pins
  output logic            mTimerInt,
  output logic            mSwInt,
  output logic            gpioIntr,
  input  logic [XLen-1:0] gpioPinsIn,
  output logic [XLen-1:0] gpioPinsOut,
  output logic [XLen-1:0] gpioPinsEn,
  output logic [63:0]     mTime
);

  ahbAdrT adr;
  selVecT sel;
  ahbRspT rspRam, rspClint, rspGpio, rspExt, rsp;

  ////////////////////////////////////////////////////
  // bus bundling
  ////////////////////////////////////////////////////

  // hReady loops back so every slave sees the accept edge
  assign adr = '{addr: hAddr, write: hWrite, size: hSize, trans: hTrans, ready: hReady};
  assign rspExt = '{rData: hRDataExt, ready: hReadyExt, resp: hRespExt};

  assign hRData  = rsp.rData;
  assign hReady  = rsp.ready;
  assign hResp   = rsp.resp;
  assign hSelExt = sel.ext;

  ////////////////////////////////////////////////////
  // decode, slaves, response mux
  ////////////////////////////////////////////////////

  adrDecode adrDecode (.adr, .sel);

  ahbRam ram (
    .HCLK, .arstN, .sel(sel.ram), .adr, .wData(hWData), .rsp(rspRam)
  );

  clint clint (
    .HCLK, .arstN, .sel(sel.clint), .adr, .wData(hWData), .rsp(rspClint),
    .mTimerInt, .mSwInt, .mTime
  );

  gpio gpio (
    .HCLK, .arstN, .sel(sel.gpio), .adr, .wData(hWData), .rsp(rspGpio),
    .gpioPinsIn, .gpioPinsOut, .gpioPinsEn, .gpioIntr
  );

  ahbRespMux respMux (
    .HCLK, .arstN, .sel, .rspRam, .rspClint, .rspGpio, .rspExt, .rsp
  );

endmodule

// ==== dv/uncoreTbTasks.svh ====
`ifndef UNCORE_TB_TASKS_SVH
`define UNCORE_TB_TASKS_SVH

//////////////////////////////////////////////////
// reference models
//////////////////////////////////////////////////

// ram word after a write of size bytes starting at lane
function automatic logic [XLen-1:0] mergeBytes(input logic [XLen-1:0] old,
    input logic [XLen-1:0] wd, input logic [1:0] lane, input logic [2:0] size);
  logic [XLen-1:0] res;
  int count;
  res = old;
  count = (size == SizeByte) ? 1 : (size == SizeHalf) ? 2 : 4;
  for (int b = 0; b < 4; b++) begin
    if (b >= int'(lane) && b < int'(lane) + count) res[8*b +: 8] = wd[8*b +: 8];
  end
  return res;
endfunction

// pending bits keep the uncleared ones and add enabled 0->1 transitions
function automatic logic [XLen-1:0] pendNext(input logic [XLen-1:0] ip, clr, oldPins,
    newPins, en);
  return (ip & ~clr) | (newPins & en & ~(oldPins & en));
endfunction

// read data the external slave model returns for an address
function automatic logic [XLen-1:0] extValue(input logic [31:0] a);
  return {~a[15:0], a[15:0]} ^ 32'h0F0F_3C3C;
endfunction

function automatic logic [31:0] clintAdr(input logic [15:0] off);
  return ClintBase | {16'h0, off};
endfunction

function automatic logic [31:0] gpioAdr(input logic [7:0] off);
  return GpioBase | {24'h0, off};
endfunction

//////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////

task automatic checkData(input string name, input logic [XLen-1:0] exp, act);
  checks++;
  if (act !== exp) begin
    errors++;
    $display("error %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic checkResp(input string name, input logic exp, act);
  checks++;
  if (act !== exp) begin
    errors++;
    $display("error %s: expected resp %b, actual %b", name, exp, act);
  end
endtask

task automatic checkIrq(input string name, input logic exp, act);
  checks++;
  if (act !== exp) begin
    errors++;
    $display("error %s: expected line %b, actual %b", name, exp, act);
  end
endtask

task automatic checkTime(input string name, input logic [63:0] exp, act);
  checks++;
  if (act !== exp) begin
    errors++;
    $display("error %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic reportFailure(input string msg);
  errors++;
  $display("failure: %s", msg);
endtask

//////////////////////////////////////////////////
// bus transfers
//////////////////////////////////////////////////

task automatic driveAdr(input logic [31:0] addr, input logic write, input logic [2:0] size);
  hAddr  = addr;
  hWrite = write;
  hSize  = size;
  hTrans = TransNonSeq;
endtask

task automatic driveIdle();
  hAddr  = '0;
  hWrite = 1'b0;
  hTrans = 2'b00;
endtask

// one nonsequential transfer
// waits counts data-phase cycles with hReady low
task automatic busXfer(input logic [31:0] addr, input logic write, input logic [2:0] size,
    input logic [XLen-1:0] wData, output logic [XLen-1:0] rData, output logic resp,
    output int waits);
  @(negedge HCLK);
  driveAdr(addr, write, size);
  // address phase stays on the bus until a ready edge
  @(posedge HCLK);
  while (!hReady) @(posedge HCLK);
  @(negedge HCLK);
  driveIdle();
  hWData = write ? wData : '0;
  waits = 0;
  @(posedge HCLK);
  while (!hReady) begin
    waits++;
    @(posedge HCLK);
  end
  rData = hRData;
  resp  = hResp;
endtask

task automatic writeReg(input logic [31:0] addr, input logic [2:0] size,
    input logic [XLen-1:0] data);
  logic [XLen-1:0] rd;
  logic rsp;
  int waits;
  busXfer(addr, 1'b1, size, data, rd, rsp, waits);
  checkResp("write resp", 1'b0, rsp);
endtask

task automatic readExpect(input string name, input logic [31:0] addr, input logic [2:0] size,
    input logic [XLen-1:0] exp);
  logic [XLen-1:0] rd;
  logic rsp;
  int waits;
  busXfer(addr, 1'b0, size, '0, rd, rsp, waits);
  checkData(name, exp, rd);
  checkResp(name, 1'b0, rsp);
endtask

// ram write with the read of the same word in the very next address phase
task automatic writeReadRam(input logic [31:0] addr, input logic [2:0] size,
    input logic [XLen-1:0] wData, output logic [XLen-1:0] rData);
  @(negedge HCLK);
  driveAdr(addr, 1'b1, size);
  @(posedge HCLK);
  @(negedge HCLK);
  hWData = wData;
  driveAdr(addr, 1'b0, size);
  @(posedge HCLK);
  checkResp("ram write ready", 1'b1, hReady);
  @(negedge HCLK);
  driveIdle();
  @(posedge HCLK);
  checkResp("ram read ready", 1'b1, hReady);
  rData = hRData;
endtask

`endif

// ==== dv/uncoreTb.sv ====
`timescale 1ns/1ns

module uncoreTb import uncorePkg::*;;

  localparam int RamWin   = 16;
  localparam int RamOps   = 150;
  // upper bound on bus transfers for the watchdog
  localparam int NumXfers = RamWin + 2 * RamOps + 60;

  logic            HCLK = 1'b0;
  logic            arstN;
  logic [31:0]     hAddr;
  logic [XLen-1:0] hWData, hRDataExt, hRData, gpioPinsIn, gpioPinsOut, gpioPinsEn;
  logic            hWrite, hReadyExt, hRespExt, hReady, hResp, hSelExt;
  logic [2:0]      hSize;
  logic [1:0]      hTrans;
  logic            mTimerInt, mSwInt, gpioIntr;
  logic [63:0]     mTime;

  int errors = 0;
  int checks = 0;
  int seed = 82372;
  // external slave model bookkeeping
  int extHits = 0;
  int extWaits = 0;
  // register state the pin monitor expects
  logic [XLen-1:0] expOutVal = '0;
  logic [XLen-1:0] expOutEn = '0;
  logic            expMsip = 1'b0;

  `include "uncoreTbTasks.svh"

  uncore UUT (.*);

  always #10 HCLK = ~HCLK;

  //////////////////////////////////////////////////
  // external slave with 0 to 3 wait states per access
  //////////////////////////////////////////////////

  initial begin : extSlave
    int w;
    logic [31:0] a;
    logic wr;
    forever begin
      @(posedge HCLK);
      if (arstN && hSelExt && hReady) begin
        a = hAddr;
        wr = hWrite;
        w = $unsigned($random(seed)) % 4;
        extWaits = w;
        extHits++;
        @(negedge HCLK);
        hRDataExt = wr ? '0 : extValue(a);
        hRespExt  = a[8];
        hReadyExt = (w == 0);
        while (w > 0) begin
          @(negedge HCLK);
          w--;
          hReadyExt = (w == 0);
        end
      end
    end
  end

  // pins and software interrupt follow the registers every cycle
  always @(negedge HCLK) begin
    if (arstN) begin
      checkData("gpioPinsOut", expOutVal, gpioPinsOut);
      checkData("gpioPinsEn", expOutEn, gpioPinsEn);
      checkIrq("mSwInt", expMsip, mSwInt);
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin : mainSeq
    logic [31:0] addr;
    logic [XLen-1:0] w, rd, oldPins, inEn, expIp, expIe;
    logic [XLen-1:0] ramShadow [RamWin];
    logic [2:0] sz;
    logic rsp;
    int waits, hits, idx, lane, op;
    arstN = 1'b0;
    hAddr = '0;
    hWData = '0;
    hWrite = 1'b0;
    hSize = SizeWord;
    hTrans = 2'b00;
    hRDataExt = '0;
    hReadyExt = 1'b1;
    hRespExt = 1'b0;
    gpioPinsIn = '0;
    expIp = '0;
    expIe = '0;
    repeat (16) @(negedge HCLK);
    arstN = 1'b1;

    // ram window gets known contents first
    for (int i = 0; i < RamWin; i++) begin
      w = $random(seed);
      writeReg(RamBase + i * 4, SizeWord, w);
      ramShadow[i] = w;
    end
    for (int n = 0; n < RamOps; n++) begin
      idx = $unsigned($random(seed)) % RamWin;
      sz = 3'($unsigned($random(seed)) % 3);
      lane = $unsigned($random(seed)) % 4;
      lane = (sz == SizeByte) ? lane : (sz == SizeHalf) ? (lane & 2) : 0;
      addr = RamBase + idx * 4 + lane;
      op = $unsigned($random(seed)) % 3;
      w = $random(seed);
      if (op == 0) begin
        readExpect("ram read", addr, sz, ramShadow[idx]);
      end else if (op == 1) begin
        writeReg(addr, sz, w);
        ramShadow[idx] = mergeBytes(ramShadow[idx], w, addr[1:0], sz);
      end else begin
        writeReadRam(addr, sz, w, rd);
        ramShadow[idx] = mergeBytes(ramShadow[idx], w, addr[1:0], sz);
        checkData("ram read after write", ramShadow[idx], rd);
      end
    end

    // external region with alternating reads and writes
    for (int i = 0; i < 12; i++) begin
      addr = ExtBase + i * 32'h104;
      hits = extHits;
      busXfer(addr, i[0], SizeWord, $random(seed), rd, rsp, waits);
      if (extHits != hits + 1) reportFailure("hSelExt was not raised for an external access");
      if (waits != extWaits) begin
        reportFailure($sformatf("hReady low for %0d cycles, external slave asked for %0d",
          waits, extWaits));
      end
      if (!i[0]) checkData("ext read", extValue(addr), rd);
      checkResp("ext resp", addr[8], rsp);
    end

    // clint interrupts and timer
    writeReg(clintAdr(MsipOff), SizeWord, 32'h1);
    expMsip = 1'b1;
    writeReg(clintAdr(MsipOff), SizeWord, 32'h0);
    expMsip = 1'b0;
    writeReg(clintAdr(MTimeCmpOff), SizeWord, '0);
    writeReg(clintAdr(MTimeCmpHiOff), SizeWord, '0);
    @(negedge HCLK);
    checkIrq("mTimerInt at cmp 0", 1'b1, mTimerInt);
    writeReg(clintAdr(MTimeCmpOff), SizeWord, '1);
    writeReg(clintAdr(MTimeCmpHiOff), SizeWord, '1);
    @(negedge HCLK);
    checkIrq("mTimerInt at cmp ones", 1'b0, mTimerInt);
    writeReg(clintAdr(MTimeHiOff), SizeWord, '0);
    writeReg(clintAdr(MTimeOff), SizeWord, 32'h1234_0000);
    // the written value lands at the data-phase end and counts up once per clock
    @(negedge HCLK);
    checkTime("mTime port after write", 64'h0000_0000_1234_0000, mTime);
    repeat (3) @(negedge HCLK);
    checkTime("mTime port after 3 clocks", 64'h0000_0000_1234_0003, mTime);
    busXfer(clintAdr(MTimeOff), 1'b0, SizeWord, '0, rd, rsp, waits);
    checks++;
    if (rd < 32'h1234_0000 || rd > 32'h1234_0014) begin
      errors++;
      $display("error mTime readback: expected %h to %h, actual %h",
        32'h1234_0000, 32'h1234_0014, rd);
    end

    // gpio outputs, inputs and rising-edge pending
    writeReg(gpioAdr(OutputValOff), SizeWord, 32'hA5A5_1234);
    expOutVal = 32'hA5A5_1234;
    writeReg(gpioAdr(OutputEnOff), SizeWord, 32'h0000_FFFF);
    expOutEn = 32'h0000_FFFF;
    inEn = 32'h0000_00FF;
    writeReg(gpioAdr(InputEnOff), SizeWord, inEn);
    oldPins = gpioPinsIn;
    @(negedge HCLK);
    // bits 8 to 11 sit on disabled inputs
    gpioPinsIn = 32'h0000_0F03;
    repeat (5) @(negedge HCLK);
    expIp = pendNext(expIp, '0, oldPins, gpioPinsIn, inEn);
    readExpect("gpio input value", gpioAdr(InputValOff), SizeWord, gpioPinsIn & inEn);
    readExpect("gpio rise pending", gpioAdr(RiseIpOff), SizeWord, expIp);
    checkIrq("gpioIntr with riseIe clear", |(expIe & expIp), gpioIntr);
    expIe = 32'h1;
    writeReg(gpioAdr(RiseIeOff), SizeWord, expIe);
    @(negedge HCLK);
    checkIrq("gpioIntr with riseIe set", |(expIe & expIp), gpioIntr);
    writeReg(gpioAdr(RiseIpOff), SizeWord, 32'h1);
    expIp = pendNext(expIp, 32'h1, gpioPinsIn, gpioPinsIn, inEn);
    readExpect("gpio pending after clear", gpioAdr(RiseIpOff), SizeWord, expIp);
    checkIrq("gpioIntr after clear", |(expIe & expIp), gpioIntr);

    // unmapped, misaligned and sub-word accesses land on none
    readExpect("unmapped read", 32'h4000_0000, SizeWord, '0);
    readExpect("misaligned ram read", RamBase + 2, SizeWord, '0);
    writeReg(RamBase + 2, SizeWord, 32'hDEAD_BEEF);
    readExpect("ram after misaligned write", RamBase, SizeWord, ramShadow[0]);
    writeReg(clintAdr(MsipOff), SizeByte, 32'h1);
    readExpect("clint halfword read", clintAdr(MTimeCmpOff), SizeHalf, '0);
    readExpect("clint msip after byte write", clintAdr(MsipOff), SizeWord, '0);
    writeReg(gpioAdr(OutputValOff), SizeByte, 32'hFF);
    readExpect("gpio halfword read", gpioAdr(OutputValOff), SizeHalf, '0);
    readExpect("gpio out after byte write", gpioAdr(OutputValOff), SizeWord, expOutVal);
    @(negedge HCLK);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // ten cycles of 20 ns per transfer is far more than any access needs
  initial begin : watchdog
    #(NumXfers * 10 * 20);
    $display("watchdog expired, the sequence did not finish within %0d transfers", NumXfers);
    $display("checks %0d, errors %0d", checks, errors + 1);
    $display("tests failed");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+dv
rtl/uncorePkg.sv
rtl/adrDecode.sv
rtl/ahbRespMux.sv
rtl/ahbRam.sv
rtl/clint.sv
rtl/gpio.sv
rtl/uncore.sv
dv/uncoreTb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = uncoreTb
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^all tests passed$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
